//--- source/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module alu_unit
    import ex_pkg::*;
(
    input  wire logic               valid,
    input  wire alu_func_e          func,
    input  wire logic [`XLEN-1:0]   opa,
    input  wire logic [`XLEN-1:0]   opb,
    input  wire logic [`ROB_W-1:0]  rob_idx,
    input  wire logic [`PREG_W-1:0] dest_tag,
    output alu_done_t               done
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]   result;

    // Only the low bits of B count as shift amount
    assign shamt = opb[SHAMT_W-1:0];

    // ====================
    // Arithmetic
    // ====================

    always_comb begin
        case (func)
            ALU_ADD:  result = opa + opb;
            ALU_SUB:  result = opa - opb;
            ALU_SLT:  result = `XLEN'($signed(opa) < $signed(opb));
            ALU_SLTU: result = `XLEN'(opa < opb);
            ALU_AND:  result = opa & opb;
            ALU_OR:   result = opa | opb;
            ALU_XOR:  result = opa ^ opb;
            ALU_SLL:  result = opa << shamt;
            ALU_SRL:  result = opa >> shamt;
            ALU_SRA:  result = $unsigned($signed(opa) >>> shamt);
            default:  result = '0;
        endcase
    end

    // ====================
    // Completion record
    // ====================

    always_comb begin
        done.valid      = valid;
        done.rob_idx    = rob_idx;
        done.dest_pr    = dest_tag;
        // Tag zero is the hardwired x0 mapping, never written
        done.writes_reg = valid && (dest_tag != '0);
        done.result     = result;
    end

endmodule

`default_nettype wire

//--- source/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module branch_unit
    import ex_pkg::*;
(
    input  wire logic               valid,
    input  wire br_func_e           func,
    input  wire logic [`XLEN-1:0]   rs1,
    input  wire logic [`XLEN-1:0]   rs2,
    input  wire logic [`XLEN-1:0]   pc,
    input  wire logic [`XLEN-1:0]   imm,
    input  wire logic               pred_taken,
    input  wire logic [`ROB_W-1:0]  rob_idx,
    input  wire logic [`PREG_W-1:0] dest_tag,
    output br_done_t                done
);

    logic taken;
    logic is_jump;
    logic lt_s;
    logic lt_u;
    logic eq;

    // ====================
    // Condition
    // ====================

    assign eq   = (rs1 == rs2);
    assign lt_s = ($signed(rs1) < $signed(rs2));
    assign lt_u = (rs1 < rs2);

    assign is_jump = (func == BR_JAL) || (func == BR_JALR);

    always_comb begin
        case (func)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            // Unconditional jumps
            default: taken = 1'b1;
        endcase
    end

    // ====================
    // Completion record
    // ====================

    always_comb begin
        done.valid       = valid;
        done.rob_idx     = rob_idx;
        done.dest_pr     = dest_tag;
        done.writes_link = valid && is_jump && (dest_tag != '0);
        done.link        = pc + `XLEN'(`INSN_BYTES);
        done.taken       = taken;
        done.target      = pc + imm;
        // Direction check against the predictor
        done.mispredict  = valid && (taken != pred_taken);
    end

endmodule

`default_nettype wire

//--- source/complete_reg.sv
`timescale 1ns/1ps
`default_nettype none

// One stage of completion records, shared by both lanes
module complete_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clock,
    input  wire logic     rst_n,
    input  wire logic     flush,
    input  wire payload_t d,
    output payload_t      q
);

    // ====================
    // Record capture
    // ====================

    // Flush beats a capture on the same edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- source/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// ====================
// Datapath widths
// ====================

// Architectural data word
`define XLEN 32

// Physical register tag
`define PREG_W 6

// Reorder buffer index
`define ROB_W 5

// ====================
// Stage geometry
// ====================

// Results broadcast per cycle on the CDB
`define CDB_N 2

// Read port order is ALU src1, ALU src2, branch src1, branch src2
`define RD_PORTS 4

// Fixed instruction size, used for NPC and link
`define INSN_BYTES 4

`endif

//--- source/ex_pkg.sv
`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

    // ====================
    // Function encodings
    // ====================

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_func_e;

    // ALU operand A source
    typedef enum logic [1:0] {
        OPA_RS1  = 2'd0,
        OPA_NPC  = 2'd1,
        OPA_PC   = 2'd2,
        OPA_ZERO = 2'd3
    } opa_sel_e;

    // ALU operand B source
    typedef enum logic {
        OPB_RS2 = 1'b0,
        OPB_IMM = 1'b1
    } opb_sel_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5,
        BR_JAL  = 3'd6,
        BR_JALR = 3'd7
    } br_func_e;

    // ====================
    // Completion records
    // ====================

    typedef struct packed {
        logic               valid;
        logic [`ROB_W-1:0]  rob_idx;
        logic [`PREG_W-1:0] dest_pr;
        logic               writes_reg;
        logic [`XLEN-1:0]   result;
    } alu_done_t;

    typedef struct packed {
        logic               valid;
        logic [`ROB_W-1:0]  rob_idx;
        logic [`PREG_W-1:0] dest_pr;
        logic               writes_link;
        logic [`XLEN-1:0]   link;
        logic               taken;
        logic [`XLEN-1:0]   target;
        logic               mispredict;
    } br_done_t;

endpackage

`default_nettype wire

//--- source/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage
    import ex_pkg::*;
(
    input  wire logic                              clock,
    input  wire logic                              rst_n,
    input  wire logic                              flush,
    // ALU issue
    input  wire logic                              alu_valid,
    input  wire alu_func_e                         alu_func,
    input  wire opa_sel_e                          alu_opa_sel,
    input  wire opb_sel_e                          alu_opb_sel,
    input  wire logic [`XLEN-1:0]                  alu_pc,
    input  wire logic [`XLEN-1:0]                  alu_imm,
    input  wire logic [`PREG_W-1:0]                alu_src1_tag,
    input  wire logic [`PREG_W-1:0]                alu_src2_tag,
    input  wire logic [`PREG_W-1:0]                alu_dest_tag,
    input  wire logic [`ROB_W-1:0]                 alu_rob_idx,
    // Branch issue
    input  wire logic                              br_valid,
    input  wire br_func_e                          br_func,
    input  wire logic [`XLEN-1:0]                  br_pc,
    input  wire logic [`XLEN-1:0]                  br_imm,
    input  wire logic [`PREG_W-1:0]                br_src1_tag,
    input  wire logic [`PREG_W-1:0]                br_src2_tag,
    input  wire logic [`PREG_W-1:0]                br_dest_tag,
    input  wire logic [`ROB_W-1:0]                 br_rob_idx,
    input  wire logic                              br_pred_taken,
    // CDB and register file
    input  wire logic [`CDB_N-1:0]                 cdb_valid,
    input  wire logic [`CDB_N-1:0][`PREG_W-1:0]    cdb_tag,
    input  wire logic [`CDB_N-1:0][`XLEN-1:0]      cdb_data,
    input  wire logic [`RD_PORTS-1:0][`XLEN-1:0]   prf_rd_data,
    output logic      [`RD_PORTS-1:0]              prf_rd_en,
    output logic      [`RD_PORTS-1:0][`PREG_W-1:0] prf_rd_tag,
    // ALU completion
    output logic                                   alu_cmp_valid,
    output logic      [`ROB_W-1:0]                 alu_cmp_rob_idx,
    output logic      [`PREG_W-1:0]                alu_cmp_dest_pr,
    output logic                                   alu_cmp_writes_reg,
    output logic      [`XLEN-1:0]                  alu_cmp_result,
    // Branch completion
    output logic                                   br_cmp_valid,
    output logic      [`ROB_W-1:0]                 br_cmp_rob_idx,
    output logic      [`PREG_W-1:0]                br_cmp_dest_pr,
    output logic                                   br_cmp_writes_link,
    output logic      [`XLEN-1:0]                  br_cmp_link,
    output logic                                   br_cmp_taken,
    output logic      [`XLEN-1:0]                  br_cmp_target,
    output logic                                   br_cmp_mispredict
);

    logic [`XLEN-1:0] alu_opa;
    logic [`XLEN-1:0] alu_opb;
    logic [`XLEN-1:0] br_rs1;
    logic [`XLEN-1:0] br_rs2;

    alu_done_t alu_done_d;
    alu_done_t alu_done_q;
    br_done_t  br_done_d;
    br_done_t  br_done_q;

    // ====================
    // Operand decode
    // ====================

    operand_decode u_decode (
        .alu_valid    (alu_valid),
        .alu_opa_sel  (alu_opa_sel),
        .alu_opb_sel  (alu_opb_sel),
        .alu_pc       (alu_pc),
        .alu_imm      (alu_imm),
        .alu_src1_tag (alu_src1_tag),
        .alu_src2_tag (alu_src2_tag),
        .br_valid     (br_valid),
        .br_src1_tag  (br_src1_tag),
        .br_src2_tag  (br_src2_tag),
        .cdb_valid    (cdb_valid),
        .cdb_tag      (cdb_tag),
        .cdb_data     (cdb_data),
        .prf_rd_data  (prf_rd_data),
        .prf_rd_en    (prf_rd_en),
        .prf_rd_tag   (prf_rd_tag),
        .alu_opa      (alu_opa),
        .alu_opb      (alu_opb),
        .br_rs1       (br_rs1),
        .br_rs2       (br_rs2)
    );

    // ====================
    // Execute lanes
    // ====================

    alu_unit u_alu (
        .valid    (alu_valid),
        .func     (alu_func),
        .opa      (alu_opa),
        .opb      (alu_opb),
        .rob_idx  (alu_rob_idx),
        .dest_tag (alu_dest_tag),
        .done     (alu_done_d)
    );

    branch_unit u_branch (
        .valid      (br_valid),
        .func       (br_func),
        .rs1        (br_rs1),
        .rs2        (br_rs2),
        .pc         (br_pc),
        .imm        (br_imm),
        .pred_taken (br_pred_taken),
        .rob_idx    (br_rob_idx),
        .dest_tag   (br_dest_tag),
        .done       (br_done_d)
    );

    // ====================
    // Completion registers
    // ====================

    complete_reg #(.payload_t(alu_done_t)) u_alu_cmp (
        .clock (clock),
        .rst_n (rst_n),
        .flush (flush),
        .d     (alu_done_d),
        .q     (alu_done_q)
    );

    complete_reg #(.payload_t(br_done_t)) u_br_cmp (
        .clock (clock),
        .rst_n (rst_n),
        .flush (flush),
        .d     (br_done_d),
        .q     (br_done_q)
    );

    // Registered records out to loose ports
    assign alu_cmp_valid      = alu_done_q.valid;
    assign alu_cmp_rob_idx    = alu_done_q.rob_idx;
    assign alu_cmp_dest_pr    = alu_done_q.dest_pr;
    assign alu_cmp_writes_reg = alu_done_q.writes_reg;
    assign alu_cmp_result     = alu_done_q.result;

    assign br_cmp_valid       = br_done_q.valid;
    assign br_cmp_rob_idx     = br_done_q.rob_idx;
    assign br_cmp_dest_pr     = br_done_q.dest_pr;
    assign br_cmp_writes_link = br_done_q.writes_link;
    assign br_cmp_link        = br_done_q.link;
    assign br_cmp_taken       = br_done_q.taken;
    assign br_cmp_target      = br_done_q.target;
    assign br_cmp_mispredict  = br_done_q.mispredict;

endmodule

`default_nettype wire

//--- source/operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module operand_decode
    import ex_pkg::*;
(
    input  wire logic                                 alu_valid,
    input  wire opa_sel_e                             alu_opa_sel,
    input  wire opb_sel_e                             alu_opb_sel,
    input  wire logic [`XLEN-1:0]                     alu_pc,
    input  wire logic [`XLEN-1:0]                     alu_imm,
    input  wire logic [`PREG_W-1:0]                   alu_src1_tag,
    input  wire logic [`PREG_W-1:0]                   alu_src2_tag,
    input  wire logic                                 br_valid,
    input  wire logic [`PREG_W-1:0]                   br_src1_tag,
    input  wire logic [`PREG_W-1:0]                   br_src2_tag,
    input  wire logic [`CDB_N-1:0]                    cdb_valid,
    input  wire logic [`CDB_N-1:0][`PREG_W-1:0]       cdb_tag,
    input  wire logic [`CDB_N-1:0][`XLEN-1:0]         cdb_data,
    input  wire logic [`RD_PORTS-1:0][`XLEN-1:0]      prf_rd_data,
    output logic      [`RD_PORTS-1:0]                 prf_rd_en,
    output logic      [`RD_PORTS-1:0][`PREG_W-1:0]    prf_rd_tag,
    output logic      [`XLEN-1:0]                     alu_opa,
    output logic      [`XLEN-1:0]                     alu_opb,
    output logic      [`XLEN-1:0]                     br_rs1,
    output logic      [`XLEN-1:0]                     br_rs2
);

    localparam int P_ALU1 = 0;
    localparam int P_ALU2 = 1;
    localparam int P_BR1  = 2;
    localparam int P_BR2  = 3;

    logic [`RD_PORTS-1:0][`XLEN-1:0] resolved;

    // ====================
    // Read requests
    // ====================

    always_comb begin
        prf_rd_en  = '0;
        prf_rd_tag = '0;
        if (alu_valid) begin
            prf_rd_en[P_ALU1]  = 1'b1;
            prf_rd_en[P_ALU2]  = (alu_opb_sel == OPB_RS2);
            prf_rd_tag[P_ALU1] = alu_src1_tag;
            prf_rd_tag[P_ALU2] = alu_src2_tag;
        end
        if (br_valid) begin
            prf_rd_en[P_BR1]  = 1'b1;
            prf_rd_en[P_BR2]  = 1'b1;
            prf_rd_tag[P_BR1] = br_src1_tag;
            prf_rd_tag[P_BR2] = br_src2_tag;
        end
    end

    // ====================
    // CDB forwarding
    // ====================

    // Later CDB entries overwrite earlier ones, so the higher index wins
    always_comb begin
        resolved = prf_rd_data;
        for (int p = 0; p < `RD_PORTS; p++) begin
            for (int c = 0; c < `CDB_N; c++) begin
                if (cdb_valid[c] && (cdb_tag[c] == prf_rd_tag[p])) begin
                    resolved[p] = cdb_data[c];
                end
            end
        end
    end

    // ====================
    // ALU operand select
    // ====================

    always_comb begin
        case (alu_opa_sel)
            OPA_RS1:  alu_opa = resolved[P_ALU1];
            OPA_NPC:  alu_opa = alu_pc + `XLEN'(`INSN_BYTES);
            OPA_PC:   alu_opa = alu_pc;
            default:  alu_opa = '0;
        endcase
    end

    assign alu_opb = (alu_opb_sel == OPB_IMM) ? alu_imm : resolved[P_ALU2];

    // Branch lane takes both sources straight from the resolved ports
    assign br_rs1 = resolved[P_BR1];
    assign br_rs2 = resolved[P_BR2];

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/ex_pkg.sv
source/operand_decode.sv
source/alu_unit.sv
source/branch_unit.sv
source/complete_reg.sv
source/ex_stage.sv
tb/ex_stage_chk.sv
tb/ex_stage_tb.sv

//--- tb/ex_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_chk (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic flush,
    input wire logic alu_cmp_valid,
    input wire logic alu_cmp_writes_reg,
    input wire logic br_cmp_valid,
    input wire logic br_cmp_writes_link,
    input wire logic br_cmp_taken,
    input wire logic br_cmp_mispredict
);

    // ====================
    // Completion rules
    // ====================

    // Flush wins over a capture on the same edge
    flush_clears: assert property (@(posedge clock) disable iff (!rst_n)
        flush |=> !alu_cmp_valid && !br_cmp_valid)
        else $error("completion valid high in the cycle after flush");

    writes_reg_valid: assert property (@(posedge clock) disable iff (!rst_n)
        alu_cmp_writes_reg |-> alu_cmp_valid)
        else $error("alu writes_reg without valid");

    mispredict_valid: assert property (@(posedge clock) disable iff (!rst_n)
        br_cmp_mispredict |-> br_cmp_valid)
        else $error("branch mispredict without valid");

    // A link write only comes from a jump, which is always taken
    link_taken: assert property (@(posedge clock) disable iff (!rst_n)
        br_cmp_writes_link |-> br_cmp_taken)
        else $error("branch writes_link without taken");

endmodule

bind ex_stage ex_stage_chk u_chk (.*);

`default_nettype wire

//--- tb/ex_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex_consts.svh"

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int RST_CYCLES  = 16;
    localparam int N_RAND      = 200;
    localparam int N_CDB       = 200;
    localparam int N_ALU       = 10 * 4 * 2;
    localparam int N_BR        = 8 * 6 * 2;
    localparam int N_MISC      = 40;
    localparam int TEST_CYCLES = RST_CYCLES + N_RAND + N_CDB + N_ALU + N_BR + N_MISC;

    // Signed and unsigned corner operands for the branch compares
    localparam logic [`XLEN-1:0] CORNER [6] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF,
                                               32'h8000_0000, 32'h7FFF_FFFF, 32'h8000_0001};

    logic clock;
    logic rst_n;
    logic flush;
    logic alu_valid;
    alu_func_e alu_func;
    opa_sel_e alu_opa_sel;
    opb_sel_e alu_opb_sel;
    logic [`XLEN-1:0] alu_pc;
    logic [`XLEN-1:0] alu_imm;
    logic [`PREG_W-1:0] alu_src1_tag;
    logic [`PREG_W-1:0] alu_src2_tag;
    logic [`PREG_W-1:0] alu_dest_tag;
    logic [`ROB_W-1:0] alu_rob_idx;
    logic br_valid;
    br_func_e br_func;
    logic [`XLEN-1:0] br_pc;
    logic [`XLEN-1:0] br_imm;
    logic [`PREG_W-1:0] br_src1_tag;
    logic [`PREG_W-1:0] br_src2_tag;
    logic [`PREG_W-1:0] br_dest_tag;
    logic [`ROB_W-1:0] br_rob_idx;
    logic br_pred_taken;
    logic [`CDB_N-1:0] cdb_valid;
    logic [`CDB_N-1:0][`PREG_W-1:0] cdb_tag;
    logic [`CDB_N-1:0][`XLEN-1:0] cdb_data;
    logic [`RD_PORTS-1:0][`XLEN-1:0] prf_rd_data;
    logic [`RD_PORTS-1:0] prf_rd_en;
    logic [`RD_PORTS-1:0][`PREG_W-1:0] prf_rd_tag;
    logic alu_cmp_valid;
    logic [`ROB_W-1:0] alu_cmp_rob_idx;
    logic [`PREG_W-1:0] alu_cmp_dest_pr;
    logic alu_cmp_writes_reg;
    logic [`XLEN-1:0] alu_cmp_result;
    logic br_cmp_valid;
    logic [`ROB_W-1:0] br_cmp_rob_idx;
    logic [`PREG_W-1:0] br_cmp_dest_pr;
    logic br_cmp_writes_link;
    logic [`XLEN-1:0] br_cmp_link;
    logic br_cmp_taken;
    logic [`XLEN-1:0] br_cmp_target;
    logic br_cmp_mispredict;

    alu_done_t act_alu;
    br_done_t act_br;
    alu_done_t slot_alu;
    br_done_t slot_br;
    logic slot_full;
    string slot_name;
    string test_name;
    int rd_errors;
    int alu_errors;
    int br_errors;

    ex_stage dut (.*);

    initial clock = 1'b0;
    always #4 clock = ~clock;

    assign act_alu = {alu_cmp_valid, alu_cmp_rob_idx, alu_cmp_dest_pr, alu_cmp_writes_reg,
                      alu_cmp_result};
    assign act_br  = {br_cmp_valid, br_cmp_rob_idx, br_cmp_dest_pr, br_cmp_writes_link,
                      br_cmp_link, br_cmp_taken, br_cmp_target, br_cmp_mispredict};

    // ====================
    // Register file model
    // ====================

    function automatic logic [`XLEN-1:0] scramble(input logic [`PREG_W-1:0] tag);
        return (`XLEN'(tag) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
    endfunction

    always_comb begin
        for (int p = 0; p < `RD_PORTS; p++) begin
            prf_rd_data[p] = scramble(prf_rd_tag[p]);
        end
    end

    // ====================
    // Reference model
    // ====================

    // Register value after CDB bypass, entry 1 checked first
    function automatic logic [`XLEN-1:0] operand(input logic [`PREG_W-1:0] tag);
        if (cdb_valid[1] && cdb_tag[1] == tag) begin
            return cdb_data[1];
        end else if (cdb_valid[0] && cdb_tag[0] == tag) begin
            return cdb_data[0];
        end
        return scramble(tag);
    endfunction

    function automatic void expect_reads(output logic [`RD_PORTS-1:0] en,
                                         output logic [`RD_PORTS-1:0][`PREG_W-1:0] tag);
        en  = {br_valid, br_valid, alu_valid && (alu_opb_sel == OPB_RS2), alu_valid};
        tag = '0;
        if (alu_valid) begin
            tag[0] = alu_src1_tag;
            tag[1] = alu_src2_tag;
        end
        if (br_valid) begin
            tag[2] = br_src1_tag;
            tag[3] = br_src2_tag;
        end
    endfunction

    function automatic void predict_records(output alu_done_t ea, output br_done_t eb);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] r1;
        logic [`XLEN-1:0] r2;
        logic [4:0] sh;
        logic t;
        case (alu_opa_sel)
            OPA_RS1: a = operand(alu_src1_tag);
            OPA_NPC: a = alu_pc + 32'd4;
            OPA_PC:  a = alu_pc;
            default: a = '0;
        endcase
        b  = (alu_opb_sel == OPB_IMM) ? alu_imm : operand(alu_src2_tag);
        sh = b[4:0];
        ea = '0;
        eb = '0;
        case (alu_func)
            ALU_ADD:  ea.result = a + b;
            ALU_SUB:  ea.result = a - b;
            ALU_SLT:  ea.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: ea.result = (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  ea.result = a & b;
            ALU_OR:   ea.result = a | b;
            ALU_XOR:  ea.result = a ^ b;
            ALU_SLL:  ea.result = a << sh;
            ALU_SRL:  ea.result = a >> sh;
            default:  ea.result = $signed(a) >>> sh;
        endcase
        r1 = operand(br_src1_tag);
        r2 = operand(br_src2_tag);
        case (br_func)
            BR_BEQ:  t = (r1 == r2);
            BR_BNE:  t = (r1 != r2);
            BR_BLT:  t = ($signed(r1) < $signed(r2));
            BR_BGE:  t = ($signed(r1) >= $signed(r2));
            BR_BLTU: t = (r1 < r2);
            BR_BGEU: t = (r1 >= r2);
            default: t = 1'b1;
        endcase
        ea.valid       = alu_valid;
        ea.rob_idx     = alu_rob_idx;
        ea.dest_pr     = alu_dest_tag;
        ea.writes_reg  = alu_valid && (alu_dest_tag != 0);
        eb.valid       = br_valid;
        eb.rob_idx     = br_rob_idx;
        eb.dest_pr     = br_dest_tag;
        eb.writes_link = br_valid && (br_func == BR_JAL || br_func == BR_JALR)
                         && (br_dest_tag != 0);
        eb.link        = br_pc + 32'd4;
        eb.taken       = t;
        eb.target      = br_pc + br_imm;
        eb.mispredict  = br_valid && (t != br_pred_taken);
        // Reset or flush at the next edge clears both records
        if (!rst_n || flush) begin
            ea = '0;
            eb = '0;
        end
    endfunction

    // ====================
    // Compare
    // ====================

    always @(negedge clock) begin
        logic [`RD_PORTS-1:0] en;
        logic [`RD_PORTS-1:0][`PREG_W-1:0] tg;
        if (!rst_n) begin
            slot_alu  = '0;
            slot_br   = '0;
            slot_full = 1'b1;
        end
        if (slot_full || slot_alu.valid) begin
            assert (act_alu == slot_alu) else begin
                alu_errors++;
                $display("error %s alu: expected %h, actual %h", slot_name, slot_alu, act_alu);
            end
        end else begin
            assert (!act_alu.valid && !act_alu.writes_reg) else begin
                alu_errors++;
                $display("error %s alu flags: expected 00, actual %b%b", slot_name,
                         act_alu.valid, act_alu.writes_reg);
            end
        end
        if (slot_full || slot_br.valid) begin
            assert (act_br == slot_br) else begin
                br_errors++;
                $display("error %s branch: expected %h, actual %h", slot_name, slot_br, act_br);
            end
        end else begin
            assert (!act_br.valid && !act_br.writes_link && !act_br.mispredict) else begin
                br_errors++;
                $display("error %s branch flags: expected 000, actual %b%b%b", slot_name,
                         act_br.valid, act_br.writes_link, act_br.mispredict);
            end
        end
        expect_reads(en, tg);
        assert (prf_rd_en == en && prf_rd_tag == tg) else begin
            rd_errors++;
            $display("error %s reads: expected %h/%h, actual %h/%h", test_name, en, tg,
                     prf_rd_en, prf_rd_tag);
        end
        predict_records(slot_alu, slot_br);
        slot_full = !rst_n || flush;
        slot_name = test_name;
    end

    // ====================
    // Stimulus
    // ====================

    task automatic issue_random(input string name, input bit aim_cdb);
        logic [`RD_PORTS-1:0][`PREG_W-1:0] tags;
        for (int p = 0; p < `RD_PORTS; p++) begin
            tags[p] = `PREG_W'($urandom);
        end
        @(posedge clock);
        test_name     <= name;
        flush         <= 1'b0;
        alu_valid     <= 1'($urandom);
        alu_func      <= alu_func_e'($urandom_range(9, 0));
        alu_opa_sel   <= opa_sel_e'($urandom_range(3, 0));
        alu_opb_sel   <= opb_sel_e'($urandom_range(1, 0));
        alu_pc        <= $urandom;
        alu_imm       <= $urandom;
        alu_src1_tag  <= tags[0];
        alu_src2_tag  <= tags[1];
        alu_dest_tag  <= ($urandom_range(3, 0) == 0) ? '0 : `PREG_W'($urandom);
        alu_rob_idx   <= `ROB_W'($urandom);
        br_valid      <= 1'($urandom);
        br_func       <= br_func_e'($urandom_range(7, 0));
        br_pc         <= $urandom;
        br_imm        <= $urandom;
        br_src1_tag   <= tags[2];
        br_src2_tag   <= tags[3];
        br_dest_tag   <= ($urandom_range(3, 0) == 0) ? '0 : `PREG_W'($urandom);
        br_rob_idx    <= `ROB_W'($urandom);
        br_pred_taken <= 1'($urandom);
        for (int c = 0; c < `CDB_N; c++) begin
            cdb_valid[c] <= 1'($urandom);
            cdb_data[c]  <= $urandom;
            // Aimed entries land on a read tag, sometimes both on the same one
            cdb_tag[c]   <= aim_cdb ? tags[$urandom_range(3, 0)] : `PREG_W'($urandom);
        end
    endtask

    initial begin
        void'($urandom(32'haf3f94b3));
        rd_errors = 0;
        alu_errors = 0;
        br_errors = 0;
        slot_alu = '0;
        slot_br = '0;
        slot_full = 1'b1;
        slot_name = "reset";
        test_name = "reset";
        rst_n = 1'b0;
        flush = 1'b0;
        alu_valid = 1'b0;
        alu_func = ALU_ADD;
        alu_opa_sel = OPA_RS1;
        alu_opb_sel = OPB_RS2;
        alu_pc = '0;
        alu_imm = '0;
        alu_src1_tag = '0;
        alu_src2_tag = '0;
        alu_dest_tag = '0;
        alu_rob_idx = '0;
        br_valid = 1'b0;
        br_func = BR_BEQ;
        br_pc = '0;
        br_imm = '0;
        br_src1_tag = '0;
        br_src2_tag = '0;
        br_dest_tag = '0;
        br_rob_idx = '0;
        br_pred_taken = 1'b0;
        cdb_valid = '0;
        cdb_tag = '0;
        cdb_data = '0;
        repeat (RST_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        repeat (N_RAND) issue_random("reads", 1'b0);
        repeat (N_CDB) issue_random("cdb", 1'b1);
        for (int f = 0; f < 10; f++) begin
            for (int s = 0; s < 8; s++) begin
                issue_random("alu", 1'b0);
                alu_valid   <= 1'b1;
                alu_func    <= alu_func_e'(f);
                alu_opa_sel <= opa_sel_e'(s / 2);
                alu_opb_sel <= opb_sel_e'(s % 2);
            end
        end
        for (int f = 0; f < 8; f++) begin
            for (int i = 0; i < 12; i++) begin
                issue_random("branch", 1'b0);
                br_valid      <= 1'b1;
                br_func       <= br_func_e'(f);
                br_pred_taken <= 1'(i % 2);
                br_src1_tag   <= `PREG_W'(1);
                br_src2_tag   <= `PREG_W'(2);
                cdb_valid     <= 2'b11;
                cdb_tag[0]    <= `PREG_W'(1);
                cdb_tag[1]    <= `PREG_W'(2);
                cdb_data[0]   <= CORNER[i / 2];
                cdb_data[1]   <= CORNER[(i / 2 * 2) % 6];
            end
        end
        for (int i = 0; i < 20; i++) begin
            issue_random("flush", 1'b1);
            flush <= (i % 3 == 0);
            // Both lanes carry a live instruction into every flush
            if (i % 3 == 0) begin
                alu_valid <= 1'b1;
                br_valid  <= 1'b1;
            end
        end
        // Reset in the middle of traffic
        for (int i = 0; i < 10; i++) begin
            issue_random("midreset", 1'b1);
            rst_n <= !(i >= 2 && i < 5);
        end
        issue_random("drain", 1'b0);
        alu_valid <= 1'b0;
        br_valid  <= 1'b0;
        repeat (2) @(posedge clock);
        $display("read errors %0d, alu errors %0d, branch errors %0d", rd_errors, alu_errors,
                 br_errors);
        if (rd_errors + alu_errors + br_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog at twice the planned run length
    initial begin
        #(TEST_CYCLES * 8 * 2);
        $display("timeout: the run did not finish within %0d ns", TEST_CYCLES * 8 * 2);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
